//--- debug_unit_top.f
hdl/debug_unit_pkg.sv
hdl/rx_command_decoder.sv
hdl/program_loader.sv
hdl/register_dump_sender.sv
hdl/debug_control_fsm.sv
hdl/debug_unit_top.sv
verification/debug_unit_checker.sv
verification/debug_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= debug_unit_tb
FILELIST  ?= debug_unit_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/debug_unit_tb.sv
`timescale 1ns/100ps

module debug_unit_tb;
    import debug_unit_pkg::*;

    localparam int     REG_COUNT    = 12;
    localparam instr_t HALT_WORD    = '1;
    localparam int     CLOCK_PERIOD = 8;
    localparam int     PROG_WORDS   = 8;
    localparam int     NO_HALT      = 1_000_000;
    // Four dumps of one byte and one acknowledge per register byte, plus load and commands.
    localparam int     TEST_BYTES   = 4 * 2 * (REG_COUNT * 4 + 1) + 64;
    localparam int     WATCHDOG_NS  = TEST_BYTES * 7 * CLOCK_PERIOD * 8;  // About 7 cycles a byte.

    logic       clock;
    logic       reset;
    logic       rx_done;
    byte_t      rx_data;
    logic       soft_reset_ack;
    logic       halt;
    reg_word_t  reg_data;
    logic       tx_start;
    byte_t      tx_data;
    logic       soft_reset;
    logic       prog_write;
    prog_addr_t prog_addr;
    instr_t     prog_data;
    logic       enable_pc;
    logic       enable_pipeline;
    reg_sel_t   reg_select;

    instr_t     prog_mem [0:(1 << PROG_ADDR_WIDTH) - 1];
    instr_t     program_words [0:PROG_WORDS - 1];
    byte_t      tx_queue [$];
    int         write_count;
    int         enable_count;
    int         run_count;
    int         halt_after;
    int         soft_reset_count;
    integer     seed;

    debug_unit_top #(
        .HALT_INSTRUCTION (HALT_WORD),
        .REG_COUNT        (REG_COUNT)
    ) dut0 (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_rx_done         (rx_done),
        .i_rx_data         (rx_data),
        .i_soft_reset_ack  (soft_reset_ack),
        .i_halt            (halt),
        .i_reg_data        (reg_data),
        .o_tx_start        (tx_start),
        .o_tx_data         (tx_data),
        .o_soft_reset      (soft_reset),
        .o_prog_write      (prog_write),
        .o_prog_addr       (prog_addr),
        .o_prog_data       (prog_data),
        .o_enable_pc       (enable_pc),
        .o_enable_pipeline (enable_pipeline),
        .o_reg_select      (reg_select)
    );

    assign reg_data = {4{byte_t'(reg_select)}};  // Select value in every byte.

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // Core model
    //////////////////////////////

    initial begin
        soft_reset_count = 0;
        run_count        = 0;
        halt_after       = NO_HALT;
        soft_reset_ack   = 1'b0;
        halt             = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            soft_reset_count = soft_reset ? soft_reset_count + 1 : 0;
            soft_reset_ack   = (soft_reset_count >= 3);  // Core is back after 3 cycles.
            if (enable_pc) begin
                run_count = run_count + 1;
            end
            halt = (run_count >= halt_after);
        end
    end

    // Link and program memory monitors.
    always @(negedge clock) begin
        if (tx_start) begin
            tx_queue.push_back(tx_data);
        end
        if (enable_pc) begin
            enable_count = enable_count + 1;
        end
        if (prog_write) begin
            check_addr("program_load", prog_addr_t'(write_count), prog_addr);
            prog_mem[prog_addr] = prog_data;
            write_count = write_count + 1;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_instr(input string name, input instr_t expected, input instr_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input prog_addr_t expected,
                              input prog_addr_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_fail($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic instr_t fill_word(input int addr);
        return 32'hA5A5_0000 ^ instr_t'(addr);
    endfunction

    //////////////////////////////
    // Host model
    //////////////////////////////

    task automatic send_byte(input byte_t value);
        @(posedge clock);
        #1;
        rx_data = value;
        rx_done = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        rx_done = 1'b0;
        @(posedge clock);  // Decoder sees the falling edge here.
        #1;
    endtask

    task automatic recv_byte(input string name, input byte_t expected);
        int cycles;
        cycles = 0;
        while (tx_queue.size() == 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > 200) begin
                report_fail($sformatf("%s: no byte arrived from the DUT", name));
            end
        end
        check_byte(name, expected, tx_queue.pop_front());
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) @(posedge clock);
        if (tx_queue.size() != 0) begin
            report_fail($sformatf("%s: the DUT sent a byte it should have held back", name));
        end
    endtask

    task automatic configure_core(input int halt_cycles);
        @(negedge clock);
        run_count    = 0;
        halt_after   = halt_cycles;
        enable_count = 0;
    endtask

    // Receives a full dump. A wrong acknowledge goes in at one byte when wrong_reg >= 0.
    task automatic run_dump(input string name, input int wrong_reg, input int wrong_pos);
        for (int r = 0; r < REG_COUNT; r++) begin
            for (int k = 0; k < 4; k++) begin
                recv_byte(name, byte_t'(r + REG_SELECT_OFFSET));
                if (r == wrong_reg && k == wrong_pos) begin
                    send_byte(byte_t'((((k + 1) % 4) + 1) * ACK_BYTE_STEP));
                    expect_quiet(name, 10);
                end
                send_byte(byte_t'((k + 1) * ACK_BYTE_STEP));
            end
        end
        recv_byte(name, REPLY_END);
        send_byte(ACK_END);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_soft_reset();
        int cycles;
        cycles = 0;
        send_byte(CMD_SOFT_RESET);
        while (!soft_reset) begin
            @(negedge clock);
            cycles++;
            if (cycles > 10) begin
                report_fail("soft_reset: o_soft_reset did not rise after the command");
            end
        end
        recv_byte("soft_reset", REPLY_READY);
        expect_quiet("soft_reset", 20);  // Exactly one reply.
    endtask

    task automatic test_program_load();
        instr_t word;
        send_byte(CMD_LOAD);
        for (int i = 0; i < PROG_WORDS; i++) begin
            word = $random(seed);
            if (word == HALT_WORD) begin
                word = '0;
            end
            program_words[i] = word;
            for (int b = 3; b >= 0; b--) begin
                send_byte(word[8 * b +: 8]);  // MSB first.
            end
        end
        for (int b = 3; b >= 0; b--) begin
            send_byte(HALT_WORD[8 * b +: 8]);
        end
        repeat (5) @(posedge clock);
        check_instr("program_load halt word", fill_word(PROG_WORDS), prog_mem[PROG_WORDS]);
        check_cycles("program_load writes", PROG_WORDS, write_count);
        for (int i = 0; i < PROG_WORDS; i++) begin
            check_instr($sformatf("program_load word %0d", i), program_words[i], prog_mem[i]);
        end
    endtask

    task automatic test_step_run(input string name, input int wrong_reg, input int wrong_pos);
        configure_core(NO_HALT);
        send_byte(CMD_RUN_STEP);
        run_dump(name, wrong_reg, wrong_pos);
        check_cycles(name, 1, enable_count);  // One clock of execution.
    endtask

    task automatic test_wrong_ack();
        test_step_run("wrong_ack", 3, 2);
    endtask

    task automatic test_continuous_run();
        configure_core(5);
        send_byte(CMD_RUN_CONT);
        run_dump("continuous_run", -1, 0);
        check_cycles("continuous_run", 5, enable_count);
        configure_core(NO_HALT);
    endtask

    initial begin
        seed         = 99007;
        reset        = 1'b0;
        rx_done      = 1'b0;
        rx_data      = '0;
        write_count  = 0;
        enable_count = 0;
        for (int a = 0; a < (1 << PROG_ADDR_WIDTH); a++) begin
            prog_mem[a] = fill_word(a);
        end
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;
        test_soft_reset();
        test_program_load();
        test_step_run("step_run_first", -1, 0);
        test_step_run("step_run_second", -1, 0);  // No reload in between.
        test_wrong_ack();
        test_continuous_run();
        repeat (10) @(posedge clock);
        if (tx_queue.size() == 0 && !enable_pc) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_fail("the DUT was still active after the last dump");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_fail("watchdog: the tests did not finish in time");
    end

endmodule

//--- verification/debug_unit_checker.sv
`timescale 1ns/100ps

module debug_unit_checker (
    input logic i_clock,
    input logic i_reset,
    input logic i_tx_start,
    input logic i_prog_write,
    input logic i_enable_pc,
    input logic i_enable_pipeline
);

    tx_start_single: assert property (
        @(posedge i_clock) disable iff (!i_reset) i_tx_start |=> !i_tx_start
    ) else $error("o_tx_start held for two cycles");

    // Loading and running never overlap.
    write_not_running: assert property (
        @(posedge i_clock) disable iff (!i_reset) !(i_prog_write && i_enable_pc)
    ) else $error("o_prog_write high while o_enable_pc is high");

    enables_match: assert property (
        @(posedge i_clock) disable iff (!i_reset) i_enable_pipeline == i_enable_pc
    ) else $error("o_enable_pipeline differs from o_enable_pc");

endmodule

bind debug_unit_top debug_unit_checker u_checker (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_tx_start        (o_tx_start),
    .i_prog_write      (o_prog_write),
    .i_enable_pc       (o_enable_pc),
    .i_enable_pipeline (o_enable_pipeline)
);

//--- hdl/debug_unit_top.sv
`timescale 1ns/100ps

module debug_unit_top #(
    parameter debug_unit_pkg::instr_t HALT_INSTRUCTION = '1,
    parameter int                     REG_COUNT        = 12
) (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx_done,
    input  debug_unit_pkg::byte_t      i_rx_data,
    input  logic                       i_soft_reset_ack,
    input  logic                       i_halt,
    input  debug_unit_pkg::reg_word_t  i_reg_data,
    output logic                       o_tx_start,
    output debug_unit_pkg::byte_t      o_tx_data,
    output logic                       o_soft_reset,
    output logic                       o_prog_write,
    output debug_unit_pkg::prog_addr_t o_prog_addr,
    output debug_unit_pkg::instr_t     o_prog_data,
    output logic                       o_enable_pc,
    output logic                       o_enable_pipeline,
    output debug_unit_pkg::reg_sel_t   o_reg_select
);
    import debug_unit_pkg::*;

    logic       byte_valid;
    byte_t      rx_byte;
    logic       cmd_soft_reset;
    logic       cmd_load;
    logic       cmd_run;
    logic       run_step;
    logic       ack_byte;
    ack_index_t ack_index;
    logic       ack_end;
    logic       load_active;
    logic       load_done;
    logic       dump_start;
    logic       dump_done;
    logic       reply_ready_req;

    rx_command_decoder u_rx_decoder (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_rx_done        (i_rx_done),
        .i_rx_data        (i_rx_data),
        .o_byte_valid     (byte_valid),
        .o_byte           (rx_byte),
        .o_cmd_soft_reset (cmd_soft_reset),
        .o_cmd_load       (cmd_load),
        .o_cmd_run        (cmd_run),
        .o_run_step       (run_step),
        .o_ack_byte       (ack_byte),
        .o_ack_index      (ack_index),
        .o_ack_end        (ack_end)
    );

    program_loader #(
        .HALT_INSTRUCTION (HALT_INSTRUCTION)
    ) u_program_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_active (load_active),
        .i_byte_valid  (byte_valid),
        .i_byte        (rx_byte),
        .o_prog_write  (o_prog_write),
        .o_prog_addr   (o_prog_addr),
        .o_prog_data   (o_prog_data),
        .o_load_done   (load_done)
    );

    register_dump_sender #(
        .REG_COUNT (REG_COUNT)
    ) u_dump_sender (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_dump_start      (dump_start),
        .i_reply_ready_req (reply_ready_req),
        .i_reg_data        (i_reg_data),
        .i_ack_byte        (ack_byte),
        .i_ack_index       (ack_index),
        .i_ack_end         (ack_end),
        .o_reg_select      (o_reg_select),
        .o_tx_start        (o_tx_start),
        .o_tx_data         (o_tx_data),
        .o_dump_done       (dump_done)
    );

    debug_control_fsm u_control_fsm (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_cmd_soft_reset  (cmd_soft_reset),
        .i_cmd_load        (cmd_load),
        .i_cmd_run         (cmd_run),
        .i_run_step        (run_step),
        .i_soft_reset_ack  (i_soft_reset_ack),
        .i_load_done       (load_done),
        .i_halt            (i_halt),
        .i_dump_done       (dump_done),
        .o_soft_reset      (o_soft_reset),
        .o_reply_ready_req (reply_ready_req),
        .o_load_active     (load_active),
        .o_enable_pc       (o_enable_pc),
        .o_enable_pipeline (o_enable_pipeline),
        .o_dump_start      (dump_start)
    );

endmodule

//--- hdl/debug_control_fsm.sv
`timescale 1ns/100ps

module debug_control_fsm (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_cmd_soft_reset,
    input  logic i_cmd_load,
    input  logic i_cmd_run,
    input  logic i_run_step,
    input  logic i_soft_reset_ack,
    input  logic i_load_done,
    input  logic i_halt,
    input  logic i_dump_done,
    output logic o_soft_reset,
    output logic o_reply_ready_req,
    output logic o_load_active,
    output logic o_enable_pc,
    output logic o_enable_pipeline,
    output logic o_dump_start
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOFT_RESET,
        ST_WAIT_LOAD,
        ST_LOADING,
        ST_WAIT_START,
        ST_RUNNING,
        ST_DUMPING
    } dbg_state_t;

    dbg_state_t state;
    dbg_state_t state_next;
    logic       step_mode;   // Latched with the run command.
    logic       halt_seen;
    logic       run_enable;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_cmd_soft_reset) state_next = ST_SOFT_RESET;
            end
            ST_SOFT_RESET: begin
                if (i_soft_reset_ack) state_next = ST_WAIT_LOAD;  // Core is back.
            end
            ST_WAIT_LOAD: begin
                if (i_cmd_soft_reset)  state_next = ST_SOFT_RESET;
                else if (i_cmd_load)   state_next = ST_LOADING;
            end
            ST_LOADING: begin
                if (i_load_done) state_next = ST_WAIT_START;
            end
            ST_WAIT_START: begin
                if (i_cmd_soft_reset) state_next = ST_SOFT_RESET;
                else if (i_cmd_run)   state_next = ST_RUNNING;
            end
            ST_RUNNING: begin
                if (step_mode || i_halt) state_next = ST_DUMPING;  // Step runs one clock.
            end
            ST_DUMPING: begin
                if (i_dump_done) begin
                    // Another step may follow unless the program has ended.
                    state_next = (step_mode && !halt_seen) ? ST_WAIT_START : ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    //////////////////////////////
    // State and mode registers
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state             <= ST_IDLE;
            step_mode         <= 1'b0;
            halt_seen         <= 1'b0;
            o_reply_ready_req <= 1'b0;
            o_dump_start      <= 1'b0;
        end else begin
            state             <= state_next;
            o_reply_ready_req <= (state == ST_SOFT_RESET) && (state_next == ST_WAIT_LOAD);
            o_dump_start      <= (state == ST_RUNNING) && (state_next == ST_DUMPING);
            if ((state == ST_WAIT_START) && i_cmd_run) begin
                step_mode <= i_run_step;
                halt_seen <= 1'b0;
            end else if ((state == ST_RUNNING) && i_halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

    assign run_enable        = (state == ST_RUNNING);
    assign o_soft_reset      = (state == ST_SOFT_RESET);
    assign o_load_active     = (state == ST_LOADING);
    assign o_enable_pc       = run_enable;
    assign o_enable_pipeline = run_enable;  // Same edge as the PC enable.

endmodule

//--- hdl/register_dump_sender.sv
`timescale 1ns/100ps

module register_dump_sender #(
    parameter int REG_COUNT = 12
) (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_dump_start,
    input  logic                       i_reply_ready_req,
    input  debug_unit_pkg::reg_word_t  i_reg_data,
    input  logic                       i_ack_byte,
    input  debug_unit_pkg::ack_index_t i_ack_index,
    input  logic                       i_ack_end,
    output debug_unit_pkg::reg_sel_t   o_reg_select,
    output logic                       o_tx_start,
    output debug_unit_pkg::byte_t      o_tx_data,
    output logic                       o_dump_done
);
    import debug_unit_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT_BYTE,
        TX_WAIT_END
    } tx_state_t;

    tx_state_t  tx_state;
    reg_sel_t   reg_index;
    ack_index_t byte_index;   // Position of the byte last sent.
    logic       last_reg;
    logic       byte_acked;

    assign last_reg     = (reg_index == reg_sel_t'(REG_COUNT - 1));
    assign byte_acked   = i_ack_byte && (i_ack_index == byte_index);  // Wrong codes are dropped.
    assign o_reg_select = reg_index + REG_SELECT_OFFSET;

    // Byte on the link follows the sender state.
    always_comb begin
        case (tx_state)
            TX_WAIT_BYTE: o_tx_data = i_reg_data[{~byte_index, 3'b000} +: 8];
            TX_WAIT_END:  o_tx_data = REPLY_END;
            default:      o_tx_data = REPLY_READY;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            tx_state    <= TX_IDLE;
            reg_index   <= '0;
            byte_index  <= '0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
            case (tx_state)
                TX_IDLE: begin
                    if (i_dump_start) begin
                        reg_index  <= '0;
                        byte_index <= '0;
                        o_tx_start <= 1'b1;  // MSB of the first register.
                        tx_state   <= TX_WAIT_BYTE;
                    end else if (i_reply_ready_req) begin
                        o_tx_start <= 1'b1;  // Single byte, no acknowledge awaited.
                    end
                end
                TX_WAIT_BYTE: begin
                    if (byte_acked) begin
                        o_tx_start <= 1'b1;
                        byte_index <= byte_index + 1'b1;
                        if (byte_index == 2'd3) begin
                            if (last_reg) begin
                                tx_state <= TX_WAIT_END;  // Send the end marker.
                            end else begin
                                reg_index <= reg_index + 1'b1;
                            end
                        end
                    end
                end
                TX_WAIT_END: begin
                    if (i_ack_end) begin
                        o_dump_done <= 1'b1;
                        tx_state    <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/program_loader.sv
`timescale 1ns/100ps

module program_loader #(
    parameter debug_unit_pkg::instr_t HALT_INSTRUCTION = '1
) (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_load_active,
    input  logic                       i_byte_valid,
    input  debug_unit_pkg::byte_t      i_byte,
    output logic                       o_prog_write,
    output debug_unit_pkg::prog_addr_t o_prog_addr,
    output debug_unit_pkg::instr_t     o_prog_data,
    output logic                       o_load_done
);
    import debug_unit_pkg::*;

    instr_t     instr_shift;
    instr_t     instr_next;
    logic [1:0] byte_count;
    prog_addr_t addr_count;
    logic       take_byte;

    assign take_byte   = i_load_active && i_byte_valid;
    assign instr_next  = {instr_shift[23:0], i_byte};  // MSB first.
    assign o_prog_data = instr_shift;
    assign o_prog_addr = addr_count;

    //////////////////////////////
    // Instruction assembly
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (take_byte) begin
            instr_shift <= instr_next;
        end
    end

    //////////////////////////////
    // Byte count and write control
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_count   <= 2'd0;
            addr_count   <= '0;
            o_prog_write <= 1'b0;
            o_load_done  <= 1'b0;
        end else begin
            o_prog_write <= 1'b0;
            o_load_done  <= 1'b0;
            if (!i_load_active) begin
                byte_count <= 2'd0;  // Next load starts at address 0.
                addr_count <= '0;
            end else begin
                if (o_prog_write) begin
                    addr_count <= addr_count + 1'b1;  // Advance after the write.
                end
                if (i_byte_valid) begin
                    byte_count <= byte_count + 1'b1;
                    if (byte_count == 2'd3) begin
                        if (instr_next == HALT_INSTRUCTION) begin
                            o_load_done <= 1'b1;  // HALT is not written.
                        end else begin
                            o_prog_write <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- hdl/rx_command_decoder.sv
`timescale 1ns/100ps

module rx_command_decoder (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx_done,
    input  debug_unit_pkg::byte_t      i_rx_data,
    output logic                       o_byte_valid,
    output debug_unit_pkg::byte_t      o_byte,
    output logic                       o_cmd_soft_reset,
    output logic                       o_cmd_load,
    output logic                       o_cmd_run,
    output logic                       o_run_step,
    output logic                       o_ack_byte,
    output debug_unit_pkg::ack_index_t o_ack_index,
    output logic                       o_ack_end
);
    import debug_unit_pkg::*;

    logic       rx_done_q;
    logic       rx_fall;
    logic       ack_hit;
    ack_index_t ack_pos;

    assign rx_fall    = rx_done_q && !i_rx_done;  // End of a received byte.
    assign o_run_step = o_byte[2];                // Step bit of the run command.

    // Match the byte against the four per-byte acknowledge codes.
    always_comb begin
        ack_hit = 1'b0;
        ack_pos = '0;
        for (int k = 0; k < 4; k++) begin
            if (i_rx_data == byte_t'((k + 1) * ACK_BYTE_STEP)) begin
                ack_hit = 1'b1;
                ack_pos = ack_index_t'(k);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (rx_fall) begin
            o_byte      <= i_rx_data;
            o_ack_index <= ack_pos;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_done_q        <= 1'b0;
            o_byte_valid     <= 1'b0;
            o_cmd_soft_reset <= 1'b0;
            o_cmd_load       <= 1'b0;
            o_cmd_run        <= 1'b0;
            o_ack_byte       <= 1'b0;
            o_ack_end        <= 1'b0;
        end else begin
            rx_done_q        <= i_rx_done;
            o_byte_valid     <= rx_fall;
            o_cmd_soft_reset <= rx_fall && (i_rx_data == CMD_SOFT_RESET);
            o_cmd_load       <= rx_fall && (i_rx_data == CMD_LOAD);
            o_cmd_run        <= rx_fall && ((i_rx_data == CMD_RUN_CONT) ||
                                            (i_rx_data == CMD_RUN_STEP));
            o_ack_byte       <= rx_fall && ack_hit;
            o_ack_end        <= rx_fall && (i_rx_data == ACK_END);
        end
    end

endmodule

//--- hdl/debug_unit_pkg.sv
package debug_unit_pkg;

    //////////////////////////////
    // Widths and types
    //////////////////////////////

    localparam int PROG_ADDR_WIDTH = 10;      // Program memory depth is 1K words.

    typedef logic [7:0]                   byte_t;       // Host link byte.
    typedef logic [31:0]                  instr_t;      // Program instruction.
    typedef logic [31:0]                  reg_word_t;   // Core register value.
    typedef logic [PROG_ADDR_WIDTH-1:0]   prog_addr_t;  // Program memory address.
    typedef logic [3:0]                   reg_sel_t;    // Register bank select.
    typedef logic [1:0]                   ack_index_t;  // Byte position in a word.

    //////////////////////////////
    // Host commands
    //////////////////////////////

    localparam byte_t CMD_SOFT_RESET = 8'h00;
    localparam byte_t CMD_LOAD       = 8'h01;
    localparam byte_t CMD_RUN_CONT   = 8'h03;
    localparam byte_t CMD_RUN_STEP   = 8'h07;  // Bit 2 selects step mode.

    //////////////////////////////
    // Replies and acknowledges
    //////////////////////////////

    localparam byte_t REPLY_READY    = 8'h01;  // Sent once the core is reset.
    localparam byte_t REPLY_END      = 8'h0B;  // Closes a register dump.
    localparam byte_t ACK_END        = 8'h28;  // Host answer to REPLY_END.

    // Host acknowledge for byte k of a word is (k + 1) * ACK_BYTE_STEP,
    // with k = 0 for the most significant byte.
    localparam byte_t ACK_BYTE_STEP  = 8'h08;

    // Register 0 and 1 of the bank are not dumped.
    localparam reg_sel_t REG_SELECT_OFFSET = 4'd2;

endpackage
